// ==== hw/mem_access_pkg.sv ====
`default_nettype none

package mem_access_pkg;

    // ============================================================
    // Data path widths
    // ============================================================

    localparam int word_bits = 32;
    localparam int word_bytes = word_bits / 8;

    typedef logic [word_bits-1:0] word_t;
    typedef logic [word_bits-1:0] addr_t;    // Byte address
    typedef logic [word_bytes-1:0] strb_t;   // One bit per byte lane

    // Access width of a load or store
    typedef enum logic [1:0] {
        size_byte = 2'b00,
        size_half = 2'b01,
        size_word = 2'b10
    } lsu_size_t;

    // ============================================================
    // Data RAM geometry
    // ============================================================

    localparam int ram_words = 1024;
    localparam int ram_index_bits = 10;      // Word index, address bits 11:2

    // Bank select sits right above the byte offset, bits 3:2
    localparam int bank_bits = 2;

endpackage

`default_nettype wire

// ==== hw/pipe_slot_pkg.sv ====
`default_nettype none

package pipe_slot_pkg;

    // ============================================================
    // Instruction slot as seen by the memory stage
    // ============================================================

    typedef enum logic [1:0] {
        op_none  = 2'b00,    // Bubble
        op_alu   = 2'b01,    // Result already computed upstream
        op_load  = 2'b10,
        op_store = 2'b11
    } slot_op_t;

    localparam int reg_addr_bits = 5;

    typedef logic [reg_addr_bits-1:0] reg_addr_t;

    // ============================================================
    // Memory stage sequencing
    // ============================================================

    typedef enum logic [1:0] {
        state_idle     = 2'b00,
        state_wait_mem = 2'b01,   // Requests out, collecting ready
        state_done     = 2'b10    // Register write cycle
    } stage_state_t;

endpackage

`default_nettype wire

// ==== hw/store_format.sv ====
`timescale 1ns/1ns
`default_nettype none

module store_format (
    input  wire mem_access_pkg::lsu_size_t size,
    input  wire logic [1:0]                addr_lo,
    input  wire mem_access_pkg::word_t     sdata,
    output mem_access_pkg::word_t          wdata,
    output mem_access_pkg::strb_t          wstrb
);

    // Data goes out on every lane, the strobe picks the one that counts
    always_comb begin
        case (size)
            mem_access_pkg::size_byte: begin
                wdata = {4{sdata[7:0]}};
                wstrb = 4'b0001 << addr_lo;
            end
            mem_access_pkg::size_half: begin
                wdata = {2{sdata[15:0]}};
                if (addr_lo[1]) begin
                    wstrb = 4'b1100;    // Upper half
                end else begin
                    wstrb = 4'b0011;
                end
            end
            default: begin
                wdata = sdata;
                wstrb = 4'b1111;
            end
        endcase
    end

endmodule

`default_nettype wire

// ==== hw/load_align.sv ====
`timescale 1ns/1ns
`default_nettype none

module load_align (
    input  wire mem_access_pkg::word_t     rdata,
    input  wire logic [1:0]                addr_lo,
    input  wire mem_access_pkg::lsu_size_t size,
    input  wire logic                      is_unsigned,
    output mem_access_pkg::word_t          result
);

    mem_access_pkg::word_t shifted;

    // Bring the addressed lane down to bit 0
    assign shifted = rdata >> {addr_lo, 3'b000};

    always_comb begin
        case (size)
            mem_access_pkg::size_byte: begin
                if (is_unsigned) begin
                    result = {24'b0, shifted[7:0]};
                end else begin
                    result = {{24{shifted[7]}}, shifted[7:0]};
                end
            end
            mem_access_pkg::size_half: begin
                if (is_unsigned) begin
                    result = {16'b0, shifted[15:0]};
                end else begin
                    result = {{16{shifted[15]}}, shifted[15:0]};
                end
            end
            default: begin
                result = rdata;     // Word, aligned
            end
        endcase
    end

endmodule

`default_nettype wire

// ==== hw/data_ram.sv ====
`timescale 1ns/1ns
`default_nettype none

module data_ram (
    input  wire logic                  clock,
    input  wire logic                  reset,
    input  wire logic                  mem_valid0,
    input  wire mem_access_pkg::addr_t mem_addr0,
    input  wire mem_access_pkg::word_t mem_wdata0,
    input  wire mem_access_pkg::strb_t mem_wstrb0,
    output logic                       mem_ready0,
    output mem_access_pkg::word_t      mem_rdata0,
    input  wire logic                  mem_valid1,
    input  wire mem_access_pkg::addr_t mem_addr1,
    input  wire mem_access_pkg::word_t mem_wdata1,
    input  wire mem_access_pkg::strb_t mem_wstrb1,
    output logic                       mem_ready1,
    output mem_access_pkg::word_t      mem_rdata1
);

    mem_access_pkg::word_t mem [mem_access_pkg::ram_words];

    logic [mem_access_pkg::ram_index_bits-1:0] idx0, idx1;
    logic [mem_access_pkg::bank_bits-1:0] bank0, bank1;
    logic pend0, pend1;      // Request held over from last cycle
    logic conflict;
    logic port1_first;

    initial begin
        for (int i = 0; i < mem_access_pkg::ram_words; i++) begin
            mem[i] = '0;
        end
    end

    assign idx0 = mem_addr0[mem_access_pkg::ram_index_bits+1:2];
    assign idx1 = mem_addr1[mem_access_pkg::ram_index_bits+1:2];
    assign bank0 = mem_addr0[mem_access_pkg::bank_bits+1:2];
    assign bank1 = mem_addr1[mem_access_pkg::bank_bits+1:2];

    // ============================================================
    // Bank arbitration, port 0 wins unless port 1 already waited
    // ============================================================

    assign conflict = mem_valid0 & mem_valid1 & (bank0 == bank1);
    assign port1_first = pend1 & ~pend0;
    assign mem_ready0 = mem_valid0 & ~(conflict & port1_first);
    assign mem_ready1 = mem_valid1 & ~(conflict & ~port1_first);

    always_ff @(posedge clock) begin
        if (!reset) begin
            pend0 <= 1'b0;
            pend1 <= 1'b0;
        end else begin
            pend0 <= mem_valid0 & ~mem_ready0;
            pend1 <= mem_valid1 & ~mem_ready1;
        end
    end

    // A same-word pair shares the bank and port 1 reads after port 0 wrote
    assign mem_rdata0 = mem[idx0];
    assign mem_rdata1 = mem[idx1];

    always_ff @(posedge clock) begin
        for (int b = 0; b < mem_access_pkg::word_bytes; b++) begin
            if (mem_ready0 && mem_wstrb0[b]) begin
                mem[idx0][8*b +: 8] <= mem_wdata0[8*b +: 8];
            end
            if (mem_ready1 && mem_wstrb1[b]) begin
                mem[idx1][8*b +: 8] <= mem_wdata1[8*b +: 8];
            end
        end
    end

endmodule

`default_nettype wire

// ==== hw/memory_stage.sv ====
`timescale 1ns/1ns
`default_nettype none

module memory_stage (
    input  wire logic                      clock,
    input  wire logic                      reset,
    input  wire logic                      in_valid,
    input  wire logic                      flush,
    input  wire pipe_slot_pkg::slot_op_t   in_op0,
    input  wire mem_access_pkg::lsu_size_t in_size0,
    input  wire logic                      in_unsigned0,
    input  wire mem_access_pkg::addr_t     in_addr0,
    input  wire mem_access_pkg::word_t     in_sdata0,
    input  wire pipe_slot_pkg::reg_addr_t  in_waddr0,
    input  wire mem_access_pkg::word_t     in_wdata0,
    input  wire pipe_slot_pkg::slot_op_t   in_op1,
    input  wire mem_access_pkg::lsu_size_t in_size1,
    input  wire logic                      in_unsigned1,
    input  wire mem_access_pkg::addr_t     in_addr1,
    input  wire mem_access_pkg::word_t     in_sdata1,
    input  wire pipe_slot_pkg::reg_addr_t  in_waddr1,
    input  wire mem_access_pkg::word_t     in_wdata1,
    output logic                           mem_valid0,
    output mem_access_pkg::addr_t          mem_addr0,
    output mem_access_pkg::word_t          mem_wdata0,
    output mem_access_pkg::strb_t          mem_wstrb0,
    input  wire logic                      mem_ready0,
    output logic                           mem_valid1,
    output mem_access_pkg::addr_t          mem_addr1,
    output mem_access_pkg::word_t          mem_wdata1,
    output mem_access_pkg::strb_t          mem_wstrb1,
    input  wire logic                      mem_ready1,
    output mem_access_pkg::lsu_size_t      st_size0,
    output mem_access_pkg::word_t          st_data0,
    input  wire mem_access_pkg::word_t     st_wdata0,
    input  wire mem_access_pkg::strb_t     st_wstrb0,
    output mem_access_pkg::lsu_size_t      st_size1,
    output mem_access_pkg::word_t          st_data1,
    input  wire mem_access_pkg::word_t     st_wdata1,
    input  wire mem_access_pkg::strb_t     st_wstrb1,
    output mem_access_pkg::lsu_size_t      ld_size0,
    output logic                           ld_unsigned0,
    input  wire mem_access_pkg::word_t     ld_result0,
    output mem_access_pkg::lsu_size_t      ld_size1,
    output logic                           ld_unsigned1,
    input  wire mem_access_pkg::word_t     ld_result1,
    output logic                           reg_wren0,
    output pipe_slot_pkg::reg_addr_t       reg_waddr0,
    output mem_access_pkg::word_t          reg_wdata0,
    output logic                           reg_wren1,
    output pipe_slot_pkg::reg_addr_t       reg_waddr1,
    output mem_access_pkg::word_t          reg_wdata1,
    output logic                           stall
);

    function automatic logic uses_mem(input pipe_slot_pkg::slot_op_t op);
        return op == pipe_slot_pkg::op_load || op == pipe_slot_pkg::op_store;
    endfunction

    function automatic logic writes_reg(input pipe_slot_pkg::slot_op_t op);
        return op == pipe_slot_pkg::op_alu || op == pipe_slot_pkg::op_load;
    endfunction

    pipe_slot_pkg::stage_state_t state;
    pipe_slot_pkg::slot_op_t op0, op1;
    mem_access_pkg::lsu_size_t size0, size1;
    mem_access_pkg::addr_t addr0, addr1;
    mem_access_pkg::word_t sdata0, sdata1;
    mem_access_pkg::word_t wdata0, wdata1;     // ALU value, replaced by load data
    pipe_slot_pkg::reg_addr_t waddr0, waddr1;
    logic uns0, uns1;
    logic ready0, ready1;                      // Response already taken
    logic flushed;
    logic accept;
    logic done0, done1;

    assign stall = (state == pipe_slot_pkg::state_wait_mem);
    assign accept = in_valid & ~stall & ~flush;

    assign done0 = ~uses_mem(op0) | ready0 | mem_ready0;
    assign done1 = ~uses_mem(op1) | ready1 | mem_ready1;

    // ============================================================
    // Sequencing
    // ============================================================

    always_ff @(posedge clock) begin
        if (!reset) begin
            state <= pipe_slot_pkg::state_idle;
            op0 <= pipe_slot_pkg::op_none;
            op1 <= pipe_slot_pkg::op_none;
            ready0 <= 1'b0;
            ready1 <= 1'b0;
            flushed <= 1'b0;
        end else if (state == pipe_slot_pkg::state_wait_mem) begin
            if (mem_ready0) begin
                ready0 <= 1'b1;
            end
            if (mem_ready1) begin
                ready1 <= 1'b1;
            end
            if (flush) begin
                flushed <= 1'b1;   // Accesses still finish
            end
            if (done0 && done1) begin
                state <= pipe_slot_pkg::state_done;
            end
        end else if (accept) begin
            state <= pipe_slot_pkg::state_wait_mem;
            op0 <= in_op0;
            op1 <= in_op1;
            ready0 <= 1'b0;
            ready1 <= 1'b0;
            flushed <= 1'b0;
        end else begin
            state <= pipe_slot_pkg::state_idle;
        end
    end

    always_ff @(posedge clock) begin
        if (accept) begin
            size0 <= in_size0;
            size1 <= in_size1;
            uns0 <= in_unsigned0;
            uns1 <= in_unsigned1;
            addr0 <= in_addr0;
            addr1 <= in_addr1;
            sdata0 <= in_sdata0;
            sdata1 <= in_sdata1;
            waddr0 <= in_waddr0;
            waddr1 <= in_waddr1;
            wdata0 <= in_wdata0;
            wdata1 <= in_wdata1;
        end else if (state == pipe_slot_pkg::state_wait_mem) begin
            if (mem_ready0 && op0 == pipe_slot_pkg::op_load) begin
                wdata0 <= ld_result0;
            end
            if (mem_ready1 && op1 == pipe_slot_pkg::op_load) begin
                wdata1 <= ld_result1;
            end
        end
    end

    // ============================================================
    // Memory requests
    // ============================================================

    assign mem_valid0 = stall & uses_mem(op0) & ~ready0;
    assign mem_valid1 = stall & uses_mem(op1) & ~ready1;
    assign mem_addr0 = addr0;
    assign mem_addr1 = addr1;
    assign mem_wdata0 = st_wdata0;
    assign mem_wdata1 = st_wdata1;
    assign mem_wstrb0 = (op0 == pipe_slot_pkg::op_load) ? '0 : st_wstrb0;
    assign mem_wstrb1 = (op1 == pipe_slot_pkg::op_load) ? '0 : st_wstrb1;

    assign st_size0 = size0;
    assign st_size1 = size1;
    assign st_data0 = sdata0;
    assign st_data1 = sdata1;
    assign ld_size0 = size0;
    assign ld_size1 = size1;
    assign ld_unsigned0 = uns0;
    assign ld_unsigned1 = uns1;

    // Register writes, x0 never written
    assign reg_wren0 = (state == pipe_slot_pkg::state_done) & writes_reg(op0)
                       & (waddr0 != '0) & ~flushed & ~flush;
    assign reg_wren1 = (state == pipe_slot_pkg::state_done) & writes_reg(op1)
                       & (waddr1 != '0) & ~flushed & ~flush;
    assign reg_waddr0 = waddr0;
    assign reg_waddr1 = waddr1;
    assign reg_wdata0 = wdata0;
    assign reg_wdata1 = wdata1;

endmodule

`default_nettype wire

// ==== hw/mem_subsystem_top.sv ====
`timescale 1ns/1ns
`default_nettype none

module mem_subsystem_top (
    input  wire logic                      clock,
    input  wire logic                      reset,
    input  wire logic                      in_valid,
    input  wire logic                      flush,
    input  wire pipe_slot_pkg::slot_op_t   in_op0,
    input  wire mem_access_pkg::lsu_size_t in_size0,
    input  wire logic                      in_unsigned0,
    input  wire mem_access_pkg::addr_t     in_addr0,
    input  wire mem_access_pkg::word_t     in_sdata0,
    input  wire pipe_slot_pkg::reg_addr_t  in_waddr0,
    input  wire mem_access_pkg::word_t     in_wdata0,
    input  wire pipe_slot_pkg::slot_op_t   in_op1,
    input  wire mem_access_pkg::lsu_size_t in_size1,
    input  wire logic                      in_unsigned1,
    input  wire mem_access_pkg::addr_t     in_addr1,
    input  wire mem_access_pkg::word_t     in_sdata1,
    input  wire pipe_slot_pkg::reg_addr_t  in_waddr1,
    input  wire mem_access_pkg::word_t     in_wdata1,
    output logic                           stall,
    output logic                           reg_wren0,
    output pipe_slot_pkg::reg_addr_t       reg_waddr0,
    output mem_access_pkg::word_t          reg_wdata0,
    output logic                           reg_wren1,
    output pipe_slot_pkg::reg_addr_t       reg_waddr1,
    output mem_access_pkg::word_t          reg_wdata1
);

    // Stage to RAM
    logic mem_valid0, mem_valid1;
    logic mem_ready0, mem_ready1;
    mem_access_pkg::addr_t mem_addr0, mem_addr1;
    mem_access_pkg::word_t mem_wdata0, mem_wdata1;
    mem_access_pkg::strb_t mem_wstrb0, mem_wstrb1;
    mem_access_pkg::word_t mem_rdata0, mem_rdata1;

    // Store formatting and load alignment
    mem_access_pkg::lsu_size_t st_size0, st_size1;
    mem_access_pkg::word_t st_data0, st_data1;
    mem_access_pkg::word_t st_wdata0, st_wdata1;
    mem_access_pkg::strb_t st_wstrb0, st_wstrb1;
    mem_access_pkg::lsu_size_t ld_size0, ld_size1;
    logic ld_unsigned0, ld_unsigned1;
    mem_access_pkg::word_t ld_result0, ld_result1;

    memory_stage stage0 (.*);

    store_format sf0 (
        .size(st_size0), .addr_lo(mem_addr0[1:0]), .sdata(st_data0),
        .wdata(st_wdata0), .wstrb(st_wstrb0)
    );

    store_format sf1 (
        .size(st_size1), .addr_lo(mem_addr1[1:0]), .sdata(st_data1),
        .wdata(st_wdata1), .wstrb(st_wstrb1)
    );

    load_align la0 (
        .rdata(mem_rdata0), .addr_lo(mem_addr0[1:0]), .size(ld_size0),
        .is_unsigned(ld_unsigned0), .result(ld_result0)
    );

    load_align la1 (
        .rdata(mem_rdata1), .addr_lo(mem_addr1[1:0]), .size(ld_size1),
        .is_unsigned(ld_unsigned1), .result(ld_result1)
    );

    data_ram ram0 (.*);

endmodule

`default_nettype wire

// ==== testbench/tb_mem_subsystem.sv ====
`timescale 1ns/1ns
`default_nettype none

module tb_mem_subsystem;

    localparam int wait_limit = 20;

    logic clock, reset, in_valid, flush, stall;
    pipe_slot_pkg::slot_op_t in_op0, in_op1;
    mem_access_pkg::lsu_size_t in_size0, in_size1;
    logic in_unsigned0, in_unsigned1;
    mem_access_pkg::addr_t in_addr0, in_addr1;
    mem_access_pkg::word_t in_sdata0, in_sdata1, in_wdata0, in_wdata1;
    pipe_slot_pkg::reg_addr_t in_waddr0, in_waddr1, reg_waddr0, reg_waddr1;
    logic reg_wren0, reg_wren1;
    mem_access_pkg::word_t reg_wdata0, reg_wdata1;

    // Current slot pair and reference memory
    pipe_slot_pkg::slot_op_t s_op [2];
    mem_access_pkg::lsu_size_t s_size [2];
    logic s_uns [2];
    mem_access_pkg::addr_t s_addr [2];
    mem_access_pkg::word_t s_sdata [2];
    mem_access_pkg::word_t s_wdata [2];
    pipe_slot_pkg::reg_addr_t s_waddr [2];
    logic [31:0] model_mem [1024];
    int errors, passed, failed, mark;

    mem_subsystem_top dut0 (.*);

    always #4 clock = ~clock;

    // ============================================================
    // Reference model
    // ============================================================

    function automatic logic [31:0] load_value(input logic [31:0] a,
            input mem_access_pkg::lsu_size_t sz, input logic uns);
        logic [31:0] w;
        logic [7:0] b;
        logic [15:0] h;
        w = model_mem[a[11:2]];
        case (a[1:0])
            2'd0: b = w[7:0];
            2'd1: b = w[15:8];
            2'd2: b = w[23:16];
            default: b = w[31:24];
        endcase
        h = a[1] ? w[31:16] : w[15:0];
        if (sz == mem_access_pkg::size_byte) return uns ? {24'b0, b} : {{24{b[7]}}, b};
        if (sz == mem_access_pkg::size_half) return uns ? {16'b0, h} : {{16{h[15]}}, h};
        return w;
    endfunction

    task automatic store_value(input logic [31:0] a, input mem_access_pkg::lsu_size_t sz,
            input logic [31:0] d);
        if (sz == mem_access_pkg::size_byte) begin
            model_mem[a[11:2]][8*a[1:0] +: 8] = d[7:0];
        end else if (sz == mem_access_pkg::size_half) begin
            model_mem[a[11:2]][16*a[1] +: 16] = d[15:0];
        end else begin
            model_mem[a[11:2]] = d;
        end
    endtask

    task automatic rand_slot(input int i, input pipe_slot_pkg::slot_op_t op,
            input logic [1:0] bank, input bit pick_bank);
        logic [31:0] r;
        logic [9:0] idx;
        logic [1:0] off;
        r = $urandom_range(0, 2);
        s_size[i] = mem_access_pkg::lsu_size_t'(r[1:0]);
        r = $urandom();
        idx = r[9:0];
        if (pick_bank) idx[1:0] = bank;
        off = r[11:10];
        if (s_size[i] == mem_access_pkg::size_half) off[0] = 1'b0;
        if (s_size[i] == mem_access_pkg::size_word) off = 2'b00;
        s_addr[i] = {20'b0, idx, off};
        s_op[i] = op;
        s_uns[i] = r[12];
        s_waddr[i] = r[17:13];
        s_sdata[i] = $urandom();
        s_wdata[i] = $urandom();
    endtask

    function automatic pipe_slot_pkg::slot_op_t rand_op();
        logic [31:0] r;
        r = $urandom_range(0, 3);
        return pipe_slot_pkg::slot_op_t'(r[1:0]);
    endfunction

    task automatic drive_slots();
        in_op0 <= s_op[0];
        in_op1 <= s_op[1];
        in_size0 <= s_size[0];
        in_size1 <= s_size[1];
        in_unsigned0 <= s_uns[0];
        in_unsigned1 <= s_uns[1];
        in_addr0 <= s_addr[0];
        in_addr1 <= s_addr[1];
        in_sdata0 <= s_sdata[0];
        in_sdata1 <= s_sdata[1];
        in_waddr0 <= s_waddr[0];
        in_waddr1 <= s_waddr[1];
        in_wdata0 <= s_wdata[0];
        in_wdata1 <= s_wdata[1];
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
            input logic [31:0] exp);
        assert (got === exp) else begin
            errors++;
            $display("Mismatch %s: got %h expected %h", name, got, exp);
        end
    endtask

    task automatic check_quiet(input string phase);
        assert (!reg_wren0 && !reg_wren1) else begin
            errors++;
            $display("Register write pulse seen %s", phase);
        end
    endtask

    // ============================================================
    // One pair through the stage, with junk inputs or flush while held
    // ============================================================

    task automatic run_pair(input bit junk, input bit fl);
        int n, lat;
        logic exp_en [2];
        logic [31:0] exp_d [2];
        logic [4:0] exp_a [2];
        for (int i = 0; i < 2; i++) begin
            exp_en[i] = (s_op[i] == pipe_slot_pkg::op_alu || s_op[i] == pipe_slot_pkg::op_load)
                        && s_waddr[i] != 5'd0 && !fl;
            exp_d[i] = s_wdata[i];
            exp_a[i] = s_waddr[i];
            if (s_op[i] == pipe_slot_pkg::op_load) begin
                exp_d[i] = load_value(s_addr[i], s_size[i], s_uns[i]);
            end
            if (s_op[i] == pipe_slot_pkg::op_store) begin
                store_value(s_addr[i], s_size[i], s_sdata[i]);
            end
        end
        lat = 1;
        if (s_op[0][1] && s_op[1][1] && s_addr[0][3:2] == s_addr[1][3:2]) lat = 2;
        @(posedge clock);
        drive_slots();
        in_valid <= 1'b1;
        @(posedge clock);       // Accepted here
        if (junk) begin
            rand_slot(0, rand_op(), 2'd0, 1'b0);
            rand_slot(1, rand_op(), 2'd0, 1'b0);
            drive_slots();
        end
        flush <= fl;
        @(negedge clock);
        assert (stall) else begin
            errors++;
            $display("Stall did not rise after the pair was accepted");
        end
        check_quiet("while stall is high");
        n = 0;
        while (n < wait_limit) begin
            @(posedge clock);
            n++;
            in_valid <= 1'b0;
            flush <= 1'b0;
            @(negedge clock);
            if (!stall) break;
            check_quiet("while stall is high");
        end
        if (stall) begin
            errors++;
            $display("Timeout waiting for stall to fall");
            $display("Test failed");
            $finish;
        end else begin
            check_value("write latency", n, lat);
            check_value("reg_wren0", {31'b0, reg_wren0}, {31'b0, exp_en[0]});
            check_value("reg_wren1", {31'b0, reg_wren1}, {31'b0, exp_en[1]});
            if (exp_en[0]) check_value("reg_waddr0", {27'b0, reg_waddr0}, {27'b0, exp_a[0]});
            if (exp_en[0]) check_value("reg_wdata0", reg_wdata0, exp_d[0]);
            if (exp_en[1]) check_value("reg_waddr1", {27'b0, reg_waddr1}, {27'b0, exp_a[1]});
            if (exp_en[1]) check_value("reg_wdata1", reg_wdata1, exp_d[1]);
            @(negedge clock);
            check_quiet("in the cycle after the write");
        end
    endtask

    task automatic end_test(input string name);
        if (errors == mark) begin
            passed++;
            $display("%s: passed", name);
        end else begin
            failed++;
            $display("%s: failed with %0d errors", name, errors - mark);
        end
        mark = errors;
    endtask

    // Store pair in two different banks, then the same addresses loaded back
    task automatic store_then_load(input bit word_only, input bit fl);
        logic [1:0] b0;
        logic [31:0] r;
        r = $urandom_range(1, 3);
        b0 = 2'($urandom_range(0, 3));
        rand_slot(0, pipe_slot_pkg::op_store, b0, 1'b1);
        rand_slot(1, pipe_slot_pkg::op_store, b0 + r[1:0], 1'b1);
        if (word_only) begin
            s_size[0] = mem_access_pkg::size_word;
            s_size[1] = mem_access_pkg::size_word;
            s_addr[0][1:0] = 2'b00;
            s_addr[1][1:0] = 2'b00;
        end
        run_pair(1'b0, fl);
        s_op[0] = pipe_slot_pkg::op_load;
        s_op[1] = pipe_slot_pkg::op_load;
        r = $urandom();
        s_uns[0] = r[0];
        s_uns[1] = r[1];
        run_pair(1'b0, 1'b0);
    endtask

    initial begin
        void'($urandom(14496));
        for (int i = 0; i < 1024; i++) model_mem[i] = '0;
        errors = 0;
        passed = 0;
        failed = 0;
        mark = 0;
        clock = 1'b0;
        reset = 1'b0;
        in_valid = 1'b0;
        flush = 1'b0;
        s_op = '{pipe_slot_pkg::op_none, pipe_slot_pkg::op_none};
        s_size = '{mem_access_pkg::size_word, mem_access_pkg::size_word};
        s_uns = '{1'b0, 1'b0};
        s_addr = '{32'd0, 32'd0};
        s_sdata = '{32'd0, 32'd0};
        s_wdata = '{32'd0, 32'd0};
        s_waddr = '{5'd0, 5'd0};
        drive_slots();
        repeat (2) @(posedge clock);
        reset <= 1'b1;

        for (int k = 0; k < 30; k++) begin
            rand_slot(0, pipe_slot_pkg::op_alu, 2'd0, 1'b0);
            rand_slot(1, pipe_slot_pkg::op_alu, 2'd0, 1'b0);
            run_pair(1'b0, 1'b0);
        end
        end_test("alu pass-through");
        for (int k = 0; k < 30; k++) store_then_load(1'b1, 1'b0);
        end_test("word store and load");
        for (int k = 0; k < 60; k++) store_then_load(1'b0, 1'b0);
        end_test("byte and half widths");
        for (int k = 0; k < 40; k++) begin
            rand_slot(0, pipe_slot_pkg::op_store, 2'(k), 1'b1);
            rand_slot(1, (k % 2 == 0) ? pipe_slot_pkg::op_load : rand_op(), 2'(k), 1'b1);
            if (k % 2 == 0) begin
                s_addr[1] = s_addr[0];   // Same word, forwarded store data
                s_size[1] = s_size[0];
            end
            run_pair(1'b0, 1'b0);
        end
        end_test("bank conflict");
        for (int k = 0; k < 20; k++) begin
            rand_slot(0, rand_op(), 2'd0, 1'b0);
            rand_slot(1, rand_op(), 2'd0, 1'b0);
            run_pair(1'b1, k % 2 == 1);
        end
        for (int k = 0; k < 20; k++) store_then_load(1'b0, 1'b1);
        for (int k = 0; k < 300; k++) begin
            rand_slot(0, rand_op(), 2'd0, 1'b0);
            rand_slot(1, rand_op(), 2'd0, 1'b0);
            run_pair(1'b0, 1'b0);
        end
        end_test("back-pressure, flush and mixed traffic");

        $display("%0d tests passed, %0d failed, %0d errors", passed, failed, errors);
        if (errors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== dual_mem_stage.f ====
hw/mem_access_pkg.sv
hw/pipe_slot_pkg.sv
hw/store_format.sv
hw/load_align.sv
hw/data_ram.sv
hw/memory_stage.sv
hw/mem_subsystem_top.sv
testbench/tb_mem_subsystem.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the memory stage testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f dual_mem_stage.f --top-module tb_mem_subsystem -o tb_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/tb_sim > sim.log 2>&1
if [ $? -ne 0 ]; then
    cat sim.log
    echo "Simulation exited with an error"
    exit 1
fi

cat sim.log
if grep -q "Test failed" sim.log; then
    exit 1
fi
exit 0
